// ==== verilog/dac_ctrl_pkg.sv ====
`default_nettype none

package dac_ctrl_pkg;

  // Command opcodes in bits 31:30
  localparam logic [1:0] OP_NO_OP   = 2'd0; // Delay or trigger wait
  localparam logic [1:0] OP_DAC_WR  = 2'd1; // Followed by four value words
  localparam logic [1:0] OP_SET_CAL = 2'd2; // Channel offset update
  localparam logic [1:0] OP_CANCEL  = 2'd3; // Ends a wait with no ldac

  // Flag bit positions in the command word
  localparam int TRIG_BIT   = 29; // Wait for trigger instead of delay
  localparam int CONT_BIT   = 28; // Another command must follow
  localparam int LDAC_BIT   = 27; // Pulse ldac when the command ends
  localparam int DELAY_W    = 25; // Delay count in bits 24:0
  localparam int CAL_CH_LSB = 16; // SET_CAL channel, value sits in 15:0

  // Calibration and code limits
  localparam int          ABS_CAL_MAX = 4096;
  localparam int          NUM_CH      = 8;
  localparam int          NUM_PAIRS   = 4;     // Value words per DAC write
  localparam int          MID_CODE    = 32767; // Offset code for zero
  localparam logic [15:0] BAD_CODE    = 16'hFFFF;

  // SPI framing
  localparam logic [3:0] SPI_CMD_WRITE  = 4'b0001; // Write input register, load on ldac
  localparam int         FRAME_BITS     = 24;
  localparam int         CS_HIGH_CYCLES = 18;      // 42 cycle frame period minus 24 bits

  typedef struct packed {
    logic [1:0]         op;
    logic               trig;
    logic               cont;
    logic               ldac;
    logic [1:0]         spare;
    logic [DELAY_W-1:0] delay; // Channel and value for SET_CAL
  } cmd_word_t;

  typedef struct packed {
    logic [3:0]  cmd;
    logic        zero;
    logic [2:0]  ch;
    logic [15:0] code;
  } spi_frame_t;

  // Even channel goes out first
  typedef struct packed {
    spi_frame_t even;
    spi_frame_t odd;
  } dac_pair_t;

  typedef struct packed {
    logic underflow;
    logic unexp_trig;
    logic cal_oob;
    logic dac_val_oob;
  } err_flags_t;

endpackage

`default_nettype wire

// ==== verilog/dac_cmd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dac_cmd_sequencer import dac_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  cmd_word_t   cmd_word,
  input  logic        cmd_buf_empty,
  input  logic        trigger,
  input  logic        pair_done,
  input  logic        val_oob,
  input  logic        cal_oob,
  output logic        cmd_word_rd_en,
  output logic        waiting_for_trig,
  output logic        ldac,
  output err_flags_t  err,
  output logic        halt,
  output logic        set_cal,
  output logic [2:0]  cal_ch,
  output logic [15:0] cal_val,
  output logic        pair_req,
  output logic [31:0] pair_word,
  output logic [1:0]  pair_idx
);

  typedef enum logic [2:0] {S_IDLE, S_DELAY, S_TRIG_WAIT, S_DAC_WR, S_ERROR} state_t;

  state_t             state;
  state_t             next_state;  // Target state of the head word
  logic [DELAY_W-1:0] delay_timer;
  logic               trig_l;      // Latched flags of the running command
  logic               cont_l;
  logic               ldac_l;
  logic               need_pop;    // Next value word is due
  logic               wr_done;     // All four pairs shifted out
  logic [1:0]         pair_cnt;
  logic               finish;
  logic               cancel;
  logic               accept;
  logic               pop_data;
  logic               timed_cmd;
  logic               underflow_hit;
  logic               unexp_hit;
  logic               err_hit;

  // A waiting command has run its course
  assign finish = (state == S_DELAY && delay_timer == '0)
               || (state == S_TRIG_WAIT && trigger)
               || (state == S_DAC_WR && wr_done && !trig_l && delay_timer == '0);
  // Cancel only bites in a wait or right after the last pair
  assign cancel = (state == S_DELAY || state == S_TRIG_WAIT || (state == S_DAC_WR && wr_done))
               && !cmd_buf_empty && cmd_word.op == OP_CANCEL;
  assign accept    = (state == S_IDLE || finish) && !cmd_buf_empty && !cancel;
  assign pop_data  = state == S_DAC_WR && need_pop && !cmd_buf_empty;
  assign timed_cmd = cmd_word.op == OP_NO_OP || cmd_word.op == OP_DAC_WR;
  assign cmd_word_rd_en = accept || cancel || pop_data;

  // Missing follow-up command or missing value word
  assign underflow_hit = cmd_buf_empty
                      && ((cont_l && (finish || state == S_IDLE))
                          || (state == S_DAC_WR && need_pop));
  assign unexp_hit = trigger && state != S_TRIG_WAIT && state != S_ERROR;
  assign err_hit   = state != S_ERROR && (underflow_hit || unexp_hit || cal_oob || val_oob);

  assign halt             = state == S_ERROR;
  assign waiting_for_trig = state == S_TRIG_WAIT;

  always_comb begin
    case (cmd_word.op)
      OP_NO_OP:  next_state = cmd_word[TRIG_BIT] ? S_TRIG_WAIT : S_DELAY;
      OP_DAC_WR: next_state = S_DAC_WR;
      default:   next_state = S_IDLE; // SET_CAL and a lone CANCEL end at once
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= S_IDLE;
    end else if (err_hit) begin
      state <= S_ERROR; // Held until reset
    end else if (cancel) begin
      state <= S_IDLE;
    end else if (accept) begin
      state <= next_state;
    end else if (finish) begin
      state <= S_IDLE;  // Done and nothing queued
    end else if (state == S_DAC_WR && wr_done) begin
      state <= trig_l ? S_TRIG_WAIT : S_DELAY; // Writes done, wait still running
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      trig_l <= 1'b0;
      cont_l <= 1'b0;
      ldac_l <= 1'b0;
    end else if (accept) begin
      trig_l <= cmd_word[TRIG_BIT];
      cont_l <= cmd_word[CONT_BIT];
      ldac_l <= timed_cmd && cmd_word[LDAC_BIT]; // Only waits and writes load the DAC
    end else if (cancel) begin
      trig_l <= 1'b0;
      cont_l <= cmd_word[CONT_BIT];
      ldac_l <= 1'b0;
    end
  end

  // Delay counts down alongside the DAC writes
  always_ff @(posedge clk) begin
    if (!resetn) begin
      delay_timer <= '0;
    end else if (accept && timed_cmd && !cmd_word[TRIG_BIT]) begin
      delay_timer <= cmd_word.delay;
    end else if (cancel) begin
      delay_timer <= '0;
    end else if (delay_timer != '0) begin
      delay_timer <= delay_timer - 1'b1;
    end
  end

  // Pair sequencing, one value word in flight at a time
  always_ff @(posedge clk) begin
    if (!resetn) begin
      need_pop <= 1'b0;
      wr_done  <= 1'b0;
      pair_cnt <= 2'd0;
      pair_req <= 1'b0;
      pair_idx <= 2'd0;
    end else begin
      pair_req <= pop_data && !err_hit;
      wr_done  <= state == S_DAC_WR && pair_done && pair_idx == 2'(NUM_PAIRS - 1);
      if (accept && cmd_word.op == OP_DAC_WR) begin
        need_pop <= 1'b1; // First value word right behind the command
        pair_cnt <= 2'd0;
      end else if (pop_data) begin
        need_pop <= 1'b0;
        pair_idx <= pair_cnt;
        pair_cnt <= pair_cnt + 1'b1;
      end else if (state == S_DAC_WR && pair_done && pair_idx != 2'(NUM_PAIRS - 1)) begin
        need_pop <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop_data)
      pair_word <= cmd_word;
    if (accept) begin
      cal_ch  <= cmd_word[CAL_CH_LSB +: 3];
      cal_val <= cmd_word[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      set_cal <= 1'b0;
      ldac    <= 1'b0;
    end else begin
      set_cal <= accept && cmd_word.op == OP_SET_CAL;
      ldac    <= finish && ldac_l && !cancel && !err_hit; // Cycle after completion
    end
  end

  // Sticky error flags
  always_ff @(posedge clk) begin
    if (!resetn) begin
      err <= '0;
    end else if (state != S_ERROR) begin
      if (underflow_hit) err.underflow   <= 1'b1;
      if (unexp_hit)     err.unexp_trig  <= 1'b1;
      if (cal_oob)       err.cal_oob     <= 1'b1;
      if (val_oob)       err.dac_val_oob <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dac_cal_convert.sv ====
`timescale 1ns/1ps
`default_nettype none

module dac_cal_convert import dac_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic        set_cal,
  input  logic [2:0]  cal_ch,
  input  logic [15:0] cal_val,
  input  logic        pair_req,
  input  logic [31:0] pair_word,
  input  logic [1:0]  pair_idx,
  output logic        pair_valid,
  output dac_pair_t   dac_pair,
  output logic        val_oob,
  output logic        cal_oob
);

  logic signed [15:0] cal_tab [NUM_CH]; // Per-channel offsets
  logic               cal_in_range;
  logic               code_bad;
  logic [2:0]         even_ch;
  logic               s1_valid;
  logic [2:0]         s1_ch;
  logic signed [16:0] s1_sum_even;      // Calibrated signed values
  logic signed [16:0] s1_sum_odd;
  logic               sum_oob;

  // Offset code to signed, plus the channel offset
  function automatic logic signed [16:0] add_cal(input logic [15:0] code,
                                                 input logic signed [15:0] cal);
    add_cal = 17'($signed({1'b0, code}) - MID_CODE + cal);
  endfunction

  // Back to offset code inside a write frame
  function automatic spi_frame_t make_frame(input logic [2:0] ch,
                                            input logic signed [16:0] sum);
    make_frame.cmd  = SPI_CMD_WRITE;
    make_frame.zero = 1'b0;
    make_frame.ch   = ch;
    make_frame.code = 16'(sum + MID_CODE);
  endfunction

  assign cal_in_range = $signed(cal_val) <= ABS_CAL_MAX && $signed(cal_val) >= -ABS_CAL_MAX;
  assign code_bad     = pair_word[15:0] == BAD_CODE || pair_word[31:16] == BAD_CODE;
  assign even_ch      = {pair_idx, 1'b0}; // Low half of the word is the even channel
  assign sum_oob      = s1_sum_even > MID_CODE || s1_sum_even < -MID_CODE
                     || s1_sum_odd > MID_CODE || s1_sum_odd < -MID_CODE;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_CH; i++)
        cal_tab[i] <= '0;
      cal_oob <= 1'b0;
    end else begin
      cal_oob <= set_cal && !cal_in_range; // Rejected, table untouched
      if (set_cal && cal_in_range)
        cal_tab[cal_ch] <= $signed(cal_val);
    end
  end

  // Stage flags; a bad code stops the pair in stage one
  always_ff @(posedge clk) begin
    if (!resetn) begin
      s1_valid   <= 1'b0;
      pair_valid <= 1'b0;
      val_oob    <= 1'b0;
    end else begin
      s1_valid   <= pair_req && !code_bad;
      pair_valid <= s1_valid && !sum_oob;
      val_oob    <= (pair_req && code_bad) || (s1_valid && sum_oob);
    end
  end

  always_ff @(posedge clk) begin
    if (pair_req) begin
      s1_ch       <= even_ch;
      s1_sum_even <= add_cal(pair_word[15:0], cal_tab[even_ch]);
      s1_sum_odd  <= add_cal(pair_word[31:16], cal_tab[even_ch | 3'd1]);
    end
    if (s1_valid) begin
      dac_pair.even <= make_frame(s1_ch, s1_sum_even);
      dac_pair.odd  <= make_frame(s1_ch | 3'd1, s1_sum_odd);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dac_spi_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module dac_spi_tx import dac_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  logic      halt,
  input  logic      pair_valid,
  input  dac_pair_t dac_pair,
  output logic      n_cs,
  output logic      mosi,
  output logic      pair_done
);

  typedef enum logic [1:0] {TX_IDLE, TX_GAP, TX_SHIFT} tx_state_t;

  tx_state_t                 tx_state;
  logic [2*FRAME_BITS-1:0]   shreg;     // Both frames, even one on top
  logic [4:0]                gap_cnt;   // Remaining n_cs high cycles
  logic [4:0]                bit_cnt;   // Remaining bits of the frame
  logic                      frame_idx; // Second frame in progress

  assign mosi = shreg[2*FRAME_BITS-1]; // MSB first

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      tx_state  <= TX_IDLE;
      n_cs      <= 1'b1;
      shreg     <= '0;
      gap_cnt   <= 5'd0;
      bit_cnt   <= 5'd0;
      frame_idx <= 1'b0;
      pair_done <= 1'b0;
    end else begin
      pair_done <= 1'b0;
      case (tx_state)
        TX_IDLE: begin
          if (pair_valid) begin
            shreg     <= dac_pair;
            gap_cnt   <= 5'(CS_HIGH_CYCLES - 2); // pair_valid cycle already counts as high
            frame_idx <= 1'b0;
            tx_state  <= TX_GAP;
          end
        end
        TX_GAP: begin
          if (gap_cnt == 5'd0) begin
            n_cs     <= 1'b0;
            bit_cnt  <= 5'(FRAME_BITS - 1);
            tx_state <= TX_SHIFT;
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        TX_SHIFT: begin
          shreg <= {shreg[2*FRAME_BITS-2:0], 1'b0};
          if (bit_cnt == 5'd0) begin
            n_cs <= 1'b1; // End of frame
            if (frame_idx) begin
              pair_done <= 1'b1;
              tx_state  <= TX_IDLE;
            end else begin
              frame_idx <= 1'b1;
              gap_cnt   <= 5'(CS_HIGH_CYCLES - 1); // Full gap before odd channel
              tx_state  <= TX_GAP;
            end
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dac_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dac_ctrl_top import dac_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic [31:0] cmd_word,
  input  logic        cmd_buf_empty,
  input  logic        trigger,
  output logic        cmd_word_rd_en,
  output logic        waiting_for_trig,
  output err_flags_t  err,
  output logic        n_cs,
  output logic        mosi,
  output logic        ldac
);

  logic        halt;       // Error state, stops the SPI side
  logic        set_cal;
  logic [2:0]  cal_ch;
  logic [15:0] cal_val;
  logic        cal_oob;
  logic        pair_req;
  logic [31:0] pair_word;
  logic [1:0]  pair_idx;
  logic        pair_valid;
  dac_pair_t   dac_pair;
  logic        val_oob;
  logic        pair_done;

  dac_cmd_sequencer u_seq (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_word         (cmd_word),
    .cmd_buf_empty    (cmd_buf_empty),
    .trigger          (trigger),
    .pair_done        (pair_done),
    .val_oob          (val_oob),
    .cal_oob          (cal_oob),
    .cmd_word_rd_en   (cmd_word_rd_en),
    .waiting_for_trig (waiting_for_trig),
    .ldac             (ldac),
    .err              (err),
    .halt             (halt),
    .set_cal          (set_cal),
    .cal_ch           (cal_ch),
    .cal_val          (cal_val),
    .pair_req         (pair_req),
    .pair_word        (pair_word),
    .pair_idx         (pair_idx)
  );

  dac_cal_convert u_conv (
    .clk        (clk),
    .resetn     (resetn),
    .set_cal    (set_cal),
    .cal_ch     (cal_ch),
    .cal_val    (cal_val),
    .pair_req   (pair_req),
    .pair_word  (pair_word),
    .pair_idx   (pair_idx),
    .pair_valid (pair_valid),
    .dac_pair   (dac_pair),
    .val_oob    (val_oob),
    .cal_oob    (cal_oob)
  );

  dac_spi_tx u_tx (
    .clk        (clk),
    .resetn     (resetn),
    .halt       (halt),
    .pair_valid (pair_valid),
    .dac_pair   (dac_pair),
    .n_cs       (n_cs),
    .mosi       (mosi),
    .pair_done  (pair_done)
  );

endmodule

`default_nettype wire

// ==== verif/tb_dac_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dac_ctrl import dac_ctrl_pkg::*; ();

  logic        clk;
  logic        resetn;
  logic [31:0] cmd_word;
  logic        cmd_buf_empty;
  logic        trigger;
  logic        cmd_word_rd_en;
  logic        waiting_for_trig;
  err_flags_t  err;
  logic        n_cs;
  logic        mosi;
  logic        ldac;

  logic [31:0] cmd_q[$];      // Command buffer contents, head first
  logic [23:0] exp_frames[$]; // Reference model output
  logic [23:0] got_frames[$]; // Frames seen on the SPI pins
  int          cal[NUM_CH];   // Model of the calibration table
  integer      seed;
  int          cyc = 0;
  int          ldac_cnt;
  int          ldac_cyc;
  int          last_frame_cyc;
  int          pop_cyc;
  bit          arm_pop;       // Record the cycle of the next pop
  logic [23:0] sh;
  int          nb;

  dac_ctrl_top DUT (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_word         (cmd_word),
    .cmd_buf_empty    (cmd_buf_empty),
    .trigger          (trigger),
    .cmd_word_rd_en   (cmd_word_rd_en),
    .waiting_for_trig (waiting_for_trig),
    .err              (err),
    .n_cs             (n_cs),
    .mosi             (mosi),
    .ldac             (ldac)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // FWFT buffer pops and refreshes after the test has pushed at 1 ns
  always @(posedge clk) begin : buffer_model
    logic pop;
    pop = cmd_word_rd_en;
    if (pop && cmd_buf_empty)
      abort_run("read enable while the command buffer is empty");
    #2;
    if (pop) begin
      if (arm_pop) begin
        pop_cyc = cyc;
        arm_pop = 1'b0;
      end
      void'(cmd_q.pop_front());
    end
    cmd_buf_empty = cmd_q.size() == 0;
    cmd_word      = cmd_buf_empty ? 32'h0 : cmd_q[0];
  end

  // SPI and ldac monitor sampling at the rising edge
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!resetn) begin
      ldac_cnt = 0;
      nb       = 0;
    end else begin
      if (ldac) begin
        ldac_cnt = ldac_cnt + 1;
        ldac_cyc = cyc;
      end
      if (!n_cs) begin
        sh = {sh[22:0], mosi};
        nb = nb + 1;
        if (nb == FRAME_BITS) begin
          got_frames.push_back(sh);
          nb             = 0;
          last_frame_cyc = cyc;
        end
      end
    end
  end

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // 0 ldac count, 1 frame count, 2 any error, 3 trigger wait level, 4 buffer drained
  function automatic bit reached(input int kind, input int n);
    case (kind)
      0:       reached = ldac_cnt >= n;
      1:       reached = got_frames.size() >= n;
      2:       reached = err != '0;
      3:       reached = waiting_for_trig == n[0];
      default: reached = cmd_q.size() == 0;
    endcase
  endfunction

  task automatic wait_for(input int kind, input int n, input string what);
    int i;
    i = 0;
    while (!reached(kind, n)) begin
      if (i == 3000)
        abort_run({"timeout waiting for ", what});
      step();
      i++;
    end
  endtask

  function automatic logic [31:0] cmd_of(input logic [1:0] op, input bit trig, input bit cont,
                                         input bit ld, input int delay);
    cmd_of = {op, trig, cont, ld, 2'b00, 25'(delay)};
  endfunction

  function automatic logic [31:0] cal_cmd(input int ch, input int val);
    cal_cmd = {2'd2, 11'd0, 3'(ch), 16'(val)};
  endfunction

  // Codes leave room for any offset within +-4096
  function automatic int rand_code();
    rand_code = 5000 + int'({$random(seed)} % 55000);
  endfunction

  function automatic logic [23:0] frame_of(input int ch, input int code);
    frame_of = {4'b0001, 1'b0, 3'(ch), 16'(code + cal[ch])};
  endfunction

  task automatic push_write(input bit ld, input int delay, input int nwords);
    int lo;
    int hi;
    cmd_q.push_back(cmd_of(2'd1, 1'b0, 1'b0, ld, delay));
    for (int p = 0; p < nwords; p++) begin
      lo = rand_code();
      hi = rand_code();
      cmd_q.push_back({16'(hi), 16'(lo)}); // Low half is the even channel
      exp_frames.push_back(frame_of(2 * p, lo));
      exp_frames.push_back(frame_of(2 * p + 1, hi));
    end
  endtask

  task automatic compare_frames();
    check_value("frame count", 64'(exp_frames.size()), 64'(got_frames.size()));
    while (exp_frames.size() != 0)
      check_value("mosi frame", 64'(exp_frames.pop_front()), 64'(got_frames.pop_front()));
  endtask

  task automatic apply_reset();
    resetn  = 1'b0;
    trigger = 1'b0;
    arm_pop = 1'b0;
    cmd_q.delete();
    exp_frames.delete();
    got_frames.delete();
    for (int i = 0; i < NUM_CH; i++)
      cal[i] = 0;
    repeat (4) @(posedge clk);
    #1 resetn = 1'b1;
  endtask

  // Halt expected with at most nfr frames and no ldac
  task automatic expect_error(input logic [3:0] flags, input int nfr);
    wait_for(2, 0, "error flag");
    repeat (200) step();
    check_value("err", 64'(flags), 64'(err));
    check_value("frame count", 64'(nfr), 64'(got_frames.size()));
    check_value("ldac pulse count", 64'd0, 64'(ldac_cnt));
  endtask

  initial begin : main
    int  d;
    int  base;
    bit  is_wr;
    bit  lb;
    int  bad_cal[2];
    seed          = 32'h5b6a;
    clk           = 1'b0;
    resetn        = 1'b0;
    trigger       = 1'b0;
    cmd_word      = 32'h0;
    cmd_buf_empty = 1'b1;
    apply_reset();

    // Random offsets, then two full writes
    for (int ch = 0; ch < NUM_CH; ch++) begin
      cal[ch] = $random(seed) % (ABS_CAL_MAX + 1);
      cmd_q.push_back(cal_cmd(ch, cal[ch]));
    end
    push_write(1'b1, int'({$random(seed)} % 300), NUM_PAIRS);
    push_write(1'b1, int'({$random(seed)} % 300), NUM_PAIRS);
    wait_for(0, 2, "ldac after writes");
    wait_for(1, 16, "SPI frames");
    compare_frames();
    check_value("err", 64'd0, 64'(err));

    // One command at a time with ldac timing against the pop
    for (int n = 0; n < 8; n++) begin
      is_wr   = $random(seed) & 1;
      lb      = $random(seed) & 1;
      d       = int'({$random(seed)} % 600); // Sometimes outlasts the four pairs
      base    = ldac_cnt;
      arm_pop = 1'b1;
      if (is_wr)
        push_write(lb, d, NUM_PAIRS);
      else
        cmd_q.push_back(cmd_of(2'd0, 1'b0, 1'b0, lb, d));
      if (lb) begin
        wait_for(0, base + 1, "ldac pulse");
        check_value("ldac after delay", 64'd1, 64'(ldac_cyc - pop_cyc >= d));
        if (is_wr) begin
          check_value("frames before ldac", 64'(2 * NUM_PAIRS), 64'(got_frames.size()));
          check_value("ldac after last frame", 64'd1, 64'(ldac_cyc > last_frame_cyc));
        end
      end else begin
        wait_for(4, 0, "buffer drain");
        if (is_wr)
          wait_for(1, 8, "SPI frames");
      end
      repeat (d + 10) step(); // Window for a stray second pulse
      check_value("ldac pulse count", 64'(base + lb), 64'(ldac_cnt));
      compare_frames();
    end

    // Trigger wait ended by a trigger, then by a cancel
    apply_reset();
    cmd_q.push_back(cmd_of(2'd0, 1'b1, 1'b0, 1'b1, 0));
    wait_for(3, 1, "trigger wait");
    trigger = 1'b1;
    step();
    trigger = 1'b0;
    wait_for(0, 1, "ldac after trigger");
    check_value("waiting_for_trig", 64'd0, 64'(waiting_for_trig));
    cmd_q.push_back(cmd_of(2'd0, 1'b1, 1'b0, 1'b1, 0));
    wait_for(3, 1, "trigger wait");
    cmd_q.push_back(cmd_of(2'd3, 1'b0, 1'b0, 1'b0, 0));
    wait_for(3, 0, "cancel");
    repeat (10) step();
    check_value("ldac pulse count", 64'd1, 64'(ldac_cnt));
    check_value("err", 64'd0, 64'(err));

    // Offsets just past the bound with a write behind each
    bad_cal[0] = ABS_CAL_MAX + 1;
    bad_cal[1] = -(ABS_CAL_MAX + 1);
    for (int k = 0; k < 2; k++) begin
      apply_reset();
      cmd_q.push_back(cal_cmd(3, bad_cal[k]));
      push_write(1'b1, 5, NUM_PAIRS);
      expect_error(4'b0010, 0);
    end

    // Forbidden code in the odd half
    apply_reset();
    cmd_q.push_back(cmd_of(2'd1, 1'b0, 1'b0, 1'b1, 0));
    cmd_q.push_back({16'hFFFF, 16'd1000});
    for (int k = 0; k < 3; k++)
      cmd_q.push_back({16'd1000, 16'd1000});
    expect_error(4'b0001, 0);

    // 0xF000 plus 4096 lands above the top code
    apply_reset();
    cmd_q.push_back(cal_cmd(0, ABS_CAL_MAX));
    cmd_q.push_back(cmd_of(2'd1, 1'b0, 1'b0, 1'b1, 0));
    cmd_q.push_back({16'd1000, 16'hF000});
    for (int k = 0; k < 3; k++)
      cmd_q.push_back({16'd1000, 16'd1000});
    expect_error(4'b0001, 0);

    // Underflow cases and a stray trigger
    apply_reset();
    cmd_q.push_back(cmd_of(2'd0, 1'b0, 1'b1, 1'b0, 3));
    expect_error(4'b1000, 0);
    apply_reset();
    push_write(1'b1, 0, 2); // Two pairs, then the buffer runs dry
    expect_error(4'b1000, 4);
    compare_frames();
    apply_reset();
    step();
    trigger = 1'b1;
    step();
    trigger = 1'b0;
    expect_error(4'b0100, 0);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/dac_ctrl_pkg.sv
verilog/dac_cmd_sequencer.sv
verilog/dac_cal_convert.sv
verilog/dac_spi_tx.sv
verilog/dac_ctrl_top.sv
verif/tb_dac_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dac_ctrl
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(wildcard verilog/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): tb.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
